// File: kbd_xt_bridge.f
+incdir+bench
logic/ps2_pkg.sv
logic/xt_pkg.sv
logic/ps2_rx.sv
logic/scan_xlat.sv
logic/xt_host_fsm.sv
logic/kbd_xt_bridge.sv
bench/tb_kbd_xt_bridge.sv

// File: Bender.yml
package:
  name: kbd_xt_bridge

sources:
  - logic/ps2_pkg.sv
  - logic/xt_pkg.sv
  - logic/ps2_rx.sv
  - logic/scan_xlat.sv
  - logic/xt_host_fsm.sv
  - logic/kbd_xt_bridge.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_kbd_xt_bridge.sv

// File: bench/ps2_stim.svh
// PS/2 frame driving tasks, set-2 to set-1 reference table and ref_xt function
`ifndef ps2_stim_svh
`define ps2_stim_svh

localparam logic [7:0] f0_code = 8'hf0; // release prefix
localparam logic [7:0] self_test_code = 8'haa;

// set-1 byte for every set-2 code with code 00 in the top row's first byte
localparam logic [2047:0] xlat_rows = {
	128'hff_43_41_3f_3d_3b_3c_58_64_44_42_40_3e_0f_29_59,
	128'h65_38_2a_70_1d_10_02_5a_66_71_2c_1f_1e_11_03_5b,
	128'h67_2e_2d_20_12_05_04_5c_68_39_2f_21_14_13_06_5d,
	128'h69_31_30_23_22_15_07_5e_6a_72_32_24_16_08_09_5f,
	128'h6b_33_25_17_18_0b_0a_60_6c_34_35_26_27_19_0c_61,
	128'h6d_73_28_74_1a_0d_62_6e_3a_36_1c_1b_75_2b_63_76,
	128'h55_56_77_78_79_7a_0e_7b_7c_4f_7d_4b_47_7e_7f_6f,
	128'h52_53_50_4c_4d_48_01_45_57_4e_51_4a_37_49_46_54,
	128'h80_81_82_41_54_85_86_87_88_89_8a_8b_8c_8d_8e_8f, // 83 and 84 remapped
	128'h90_91_92_93_94_95_96_97_98_99_9a_9b_9c_9d_9e_9f,
	128'ha0_a1_a2_a3_a4_a5_a6_a7_a8_a9_aa_ab_ac_ad_ae_af,
	128'hb0_b1_b2_b3_b4_b5_b6_b7_b8_b9_ba_bb_bc_bd_be_bf,
	128'hc0_c1_c2_c3_c4_c5_c6_c7_c8_c9_ca_cb_cc_cd_ce_cf,
	128'hd0_d1_d2_d3_d4_d5_d6_d7_d8_d9_da_db_dc_dd_de_df,
	128'he0_e1_e2_e3_e4_e5_e6_e7_e8_e9_ea_eb_ec_ed_ee_ef,
	128'hf0_f1_f2_f3_f4_f5_f6_f7_f8_f9_fa_fb_fc_fd_fe_ff
};

// expected port byte for a make, a break or a reset request
function automatic logic [7:0] ref_xt(input logic [7:0] code, input logic brk,
	input logic rst_req);
	int idx;
	logic [7:0] xt;
	idx = 255 - int'(code);
	xt = xlat_rows[idx * 8 +: 8];
	if (brk)
		xt[7] = 1'b1; // release flag
	if (rst_req)
		xt = self_test_code;
	return xt;
endfunction

// any byte except the release prefix
function automatic logic [7:0] random_code();
	logic [7:0] b;
	b = 8'($urandom);
	while (b == f0_code)
		b = 8'($urandom);
	return b;
endfunction

// one keyboard bit as 4 cycles high then 4 low with data valid on the fall
task automatic send_bit(input logic b);
	@(posedge clk);
	ps2_data <= b;
	ps2_clk <= 1'b1;
	repeat (3) @(posedge clk);
	@(posedge clk);
	ps2_clk <= 1'b0;
	repeat (3) @(posedge clk);
endtask

task automatic send_frame(input logic [7:0] code);
	send_bit(1'b0); // start
	for (int i = 0; i < 8; i++)
		send_bit(code[i]);
	send_bit(~^code); // odd parity
	send_bit(1'b1); // stop
	@(posedge clk);
	ps2_clk <= 1'b1; // back to idle
	ps2_data <= 1'b1;
endtask

`endif

// File: bench/tb_kbd_xt_bridge.sv
// testbench top with clock, reset, test sequence, compare process and summary
`timescale 1ns/1ps

module tb_kbd_xt_bridge;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       ps2_clk;
	logic       ps2_data;
	logic       pb6;
	logic       pb7;
	logic [7:0] pa;
	logic       irq1;

	logic [7:0] exp_q[$]; // expected port bytes from the stimulus
	int         errors = 0;
	int         checks = 0;
	int         checks_done = 0;
	int         tests_run = 0;
	int         tests_failed = 0;
	int         err_start;
	string      test_name;
	logic       stop_run = 1'b0;

	`include "ps2_stim.svh"

	kbd_xt_bridge #(
		.sync_stages(2)
	) u_kbd_xt_bridge (
		.clk     (clk),
		.rst_n   (rst_n),
		.ps2_clk (ps2_clk),
		.ps2_data(ps2_data),
		.pb6     (pb6),
		.pb7     (pb7),
		.pa      (pa),
		.irq1    (irq1)
	);

	always #5 clk = ~clk;

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] expv);
		checks++;
		assert (got === expv) else begin
			errors++;
			$display("mismatch at %0t ns: %s is %02h, expected %02h", $time, name, got, expv);
		end
	endtask

	task automatic report_and_finish();
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	task automatic timeout_fail(input string what);
		errors++;
		$display("error at %0t ns: %s", $time, what);
		stop_run = 1'b1;
	endtask

	initial begin : stop_watch
		@(posedge stop_run);
		report_and_finish();
	end

	task automatic start_test(input string name);
		test_name = name;
		err_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == err_start) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, errors - err_start);
		end
	endtask

	// pa idle and no interrupt for n cycles
	task automatic expect_quiet(input int n);
		repeat (n) begin
			@(posedge clk);
			check_byte("pa", pa, 8'h00);
			check_byte("irq1", {7'b0, irq1}, 8'h00);
		end
	endtask

	task automatic wait_checked(input int target);
		int n;
		n = 0;
		while (checks_done < target && n < 300) begin
			@(posedge clk);
			n++;
		end
		if (checks_done < target)
			timeout_fail("the compare process never saw the queued code");
	endtask

	// PC side read acknowledge on pb7
	task automatic ack_code();
		int n;
		@(posedge clk);
		pb7 <= 1'b1;
		@(posedge clk);
		n = 0;
		while (irq1 !== 1'b0 && n < 200) begin
			@(posedge clk);
			n++;
		end
		if (irq1 !== 1'b0)
			timeout_fail("irq1 stayed high after pb7 was raised");
		@(posedge clk);
		pb7 <= 1'b0;
		@(posedge clk);
		n = 0;
		while (pa !== 8'h00 && n < 200) begin
			@(posedge clk);
			n++;
		end
		if (pa !== 8'h00)
			timeout_fail("pa did not return to 00 after the acknowledge");
		check_byte("irq1", {7'b0, irq1}, 8'h00);
	endtask

	// compare process takes one queued value per interrupt
	initial begin : compare
		logic [7:0] expected;
		int n;
		forever begin
			@(posedge clk);
			if (exp_q.size() != 0) begin
				expected = exp_q.pop_front();
				n = 0;
				while (irq1 !== 1'b1 && n < 200) begin
					@(posedge clk);
					n++;
				end
				if (irq1 !== 1'b1)
					timeout_fail("irq1 did not rise within 200 cycles");
				else
					check_byte("pa", pa, expected);
				checks_done++;
			end
		end
	end

	initial begin : stimulus
		logic [7:0] code;
		int seed_ret;
		rst_n = 1'b0;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		pb6 = 1'b1;
		pb7 = 1'b0;
		seed_ret = $urandom(32'h10dc_fadd);
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		start_test("after reset");
		expect_quiet(20);
		end_test();

		start_test("make codes");
		for (int i = 0; i < 40; i++) begin
			code = random_code();
			exp_q.push_back(ref_xt(code, 1'b0, 1'b0));
			send_frame(code);
			wait_checked(checks_done + 1);
			ack_code();
		end
		end_test();

		start_test("break sequence");
		for (int i = 0; i < 5; i++) begin
			send_frame(f0_code);
			expect_quiet(20); // prefix alone raises nothing
			code = random_code();
			exp_q.push_back(ref_xt(code, 1'b1, 1'b0));
			send_frame(code);
			wait_checked(checks_done + 1);
			ack_code();
		end
		end_test();

		start_test("reset request");
		exp_q.push_back(ref_xt(8'h00, 1'b0, 1'b1));
		@(posedge clk);
		pb6 <= 1'b0;
		repeat (10) @(posedge clk);
		pb6 <= 1'b1;
		wait_checked(checks_done + 1);
		ack_code();
		end_test();

		start_test("drop while pending");
		code = random_code();
		exp_q.push_back(ref_xt(code, 1'b0, 1'b0));
		send_frame(code);
		wait_checked(checks_done + 1);
		send_frame(random_code()); // must be ignored
		repeat (10) @(posedge clk);
		check_byte("irq1", {7'b0, irq1}, 8'h01);
		check_byte("pa", pa, ref_xt(code, 1'b0, 1'b0));
		ack_code();
		expect_quiet(100);
		end_test();

		report_and_finish();
	end

endmodule

// File: logic/kbd_xt_bridge.sv
// kbd_xt_bridge: PS/2 keyboard to PC/XT keyboard port bridge top level
`timescale 1ns/1ps

module kbd_xt_bridge #(
	parameter int sync_stages = 2
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	input  logic       pb6,
	input  logic       pb7,
	output logic [7:0] pa,
	output logic       irq1
);
	import ps2_pkg::*;
	import xt_pkg::*;

	ps2_code_t scan_code; // stable until the next frame
	logic      code_valid;
	xt_code_u  xt_code;
	xt_code_u  pa_code;

	ps2_rx #(
		.sync_stages(sync_stages)
	) u_ps2_rx (
		.clk       (clk),
		.rst_n     (rst_n),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.scan_code (scan_code),
		.code_valid(code_valid)
	);

	scan_xlat u_scan_xlat (
		.scan_code(scan_code),
		.xt_code  (xt_code)
	);

	xt_host_fsm u_xt_host_fsm (
		.clk       (clk),
		.rst_n     (rst_n),
		.code_valid(code_valid),
		.scan_code (scan_code),
		.xt_code   (xt_code),
		.pb6       (pb6),
		.pb7       (pb7),
		.pa        (pa_code),
		.irq1      (irq1)
	);

	assign pa = pa_code.raw; // PC sees the plain byte

endmodule

// File: logic/xt_host_fsm.sv
// xt_host_fsm: XT port state machine for make, break, acknowledge and reset request
`timescale 1ns/1ps

module xt_host_fsm (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               code_valid,
	input  ps2_pkg::ps2_code_t scan_code,
	input  xt_pkg::xt_code_u   xt_code,
	input  logic               pb6,
	input  logic               pb7,
	output xt_pkg::xt_code_u   pa,
	output logic               irq1
);
	import ps2_pkg::*;
	import xt_pkg::*;

	xt_state_e state;
	logic      is_prefix;

	// only the raw set-2 byte tells a release apart
	assign is_prefix = (scan_code == ps2_break_prefix);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			pa.raw <= xt_idle_code;
			irq1 <= 1'b0;
		end else begin
			irq1 <= 1'b0; // only st_hold keeps it up
			if (!pb6) begin
				// keyboard reset request, pa left as it is
				state <= st_rst_req;
			end else begin
				case (state)
					st_idle: begin
						if (code_valid) begin
							if (is_prefix) begin
								state <= st_brk;
							end else begin
								pa <= xt_code;
								state <= st_hold;
							end
						end
					end
					st_brk: begin
						// repeated F0 just keeps waiting
						if (code_valid && !is_prefix) begin
							pa.f.key <= xt_code.f.key;
							pa.f.brk <= 1'b1;
							state <= st_hold;
						end
					end
					st_hold: begin
						if (pb7) begin
							state <= st_ack;
						end else begin
							irq1 <= 1'b1;
						end
					end
					st_ack: begin
						if (!pb7) begin
							pa.raw <= xt_idle_code;
							state <= st_idle;
						end
					end
					st_rst_req: begin
						state <= st_rst_rel; // pb6 is back high here
					end
					st_rst_rel: begin
						if (!pb7) begin
							pa.raw <= xt_self_test_ok;
							state <= st_hold;
						end
					end
					default: begin
						pa.raw <= xt_idle_code;
						state <= st_idle;
					end
				endcase
			end
		end
	end

	// codes arriving outside st_idle and st_brk are simply not taken

endmodule

// File: logic/scan_xlat.sv
// scan_xlat: set-2 to set-1 scan code translation table
`timescale 1ns/1ps

module scan_xlat (
	input  ps2_pkg::ps2_code_t scan_code,
	output xt_pkg::xt_code_u   xt_code
);

	logic [7:0] xt_byte;

	always_comb begin
		case (scan_code)
			8'h00: xt_byte = 8'hff; // no key here
			8'h01: xt_byte = 8'h43;
			8'h02: xt_byte = 8'h41;
			8'h03: xt_byte = 8'h3f;
			8'h04: xt_byte = 8'h3d;
			8'h05: xt_byte = 8'h3b;
			8'h06: xt_byte = 8'h3c;
			8'h07: xt_byte = 8'h58;
			8'h08: xt_byte = 8'h64;
			8'h09: xt_byte = 8'h44;
			8'h0a: xt_byte = 8'h42;
			8'h0b: xt_byte = 8'h40;
			8'h0c: xt_byte = 8'h3e;
			8'h0d: xt_byte = 8'h0f; // tab
			8'h0e: xt_byte = 8'h29;
			8'h0f: xt_byte = 8'h59;
			8'h10: xt_byte = 8'h65;
			8'h11: xt_byte = 8'h38; // left alt
			8'h12: xt_byte = 8'h2a; // left shift
			8'h13: xt_byte = 8'h70;
			8'h14: xt_byte = 8'h1d; // left ctrl
			8'h15: xt_byte = 8'h10;
			8'h16: xt_byte = 8'h02;
			8'h17: xt_byte = 8'h5a;
			8'h18: xt_byte = 8'h66;
			8'h19: xt_byte = 8'h71;
			8'h1a: xt_byte = 8'h2c;
			8'h1b: xt_byte = 8'h1f;
			8'h1c: xt_byte = 8'h1e;
			8'h1d: xt_byte = 8'h11;
			8'h1e: xt_byte = 8'h03;
			8'h1f: xt_byte = 8'h5b;
			8'h20: xt_byte = 8'h67;
			8'h21: xt_byte = 8'h2e;
			8'h22: xt_byte = 8'h2d;
			8'h23: xt_byte = 8'h20;
			8'h24: xt_byte = 8'h12;
			8'h25: xt_byte = 8'h05;
			8'h26: xt_byte = 8'h04;
			8'h27: xt_byte = 8'h5c;
			8'h28: xt_byte = 8'h68;
			8'h29: xt_byte = 8'h39; // space
			8'h2a: xt_byte = 8'h2f;
			8'h2b: xt_byte = 8'h21;
			8'h2c: xt_byte = 8'h14;
			8'h2d: xt_byte = 8'h13;
			8'h2e: xt_byte = 8'h06;
			8'h2f: xt_byte = 8'h5d;
			8'h30: xt_byte = 8'h69;
			8'h31: xt_byte = 8'h31;
			8'h32: xt_byte = 8'h30;
			8'h33: xt_byte = 8'h23;
			8'h34: xt_byte = 8'h22;
			8'h35: xt_byte = 8'h15;
			8'h36: xt_byte = 8'h07;
			8'h37: xt_byte = 8'h5e;
			8'h38: xt_byte = 8'h6a;
			8'h39: xt_byte = 8'h72;
			8'h3a: xt_byte = 8'h32;
			8'h3b: xt_byte = 8'h24;
			8'h3c: xt_byte = 8'h16;
			8'h3d: xt_byte = 8'h08;
			8'h3e: xt_byte = 8'h09;
			8'h3f: xt_byte = 8'h5f;
			8'h40: xt_byte = 8'h6b;
			8'h41: xt_byte = 8'h33;
			8'h42: xt_byte = 8'h25;
			8'h43: xt_byte = 8'h17;
			8'h44: xt_byte = 8'h18;
			8'h45: xt_byte = 8'h0b;
			8'h46: xt_byte = 8'h0a;
			8'h47: xt_byte = 8'h60;
			8'h48: xt_byte = 8'h6c;
			8'h49: xt_byte = 8'h34;
			8'h4a: xt_byte = 8'h35;
			8'h4b: xt_byte = 8'h26;
			8'h4c: xt_byte = 8'h27;
			8'h4d: xt_byte = 8'h19;
			8'h4e: xt_byte = 8'h0c;
			8'h4f: xt_byte = 8'h61;
			8'h50: xt_byte = 8'h6d;
			8'h51: xt_byte = 8'h73;
			8'h52: xt_byte = 8'h28;
			8'h53: xt_byte = 8'h74;
			8'h54: xt_byte = 8'h1a;
			8'h55: xt_byte = 8'h0d;
			8'h56: xt_byte = 8'h62;
			8'h57: xt_byte = 8'h6e;
			8'h58: xt_byte = 8'h3a; // caps lock
			8'h59: xt_byte = 8'h36; // right shift
			8'h5a: xt_byte = 8'h1c; // enter
			8'h5b: xt_byte = 8'h1b;
			8'h5c: xt_byte = 8'h75;
			8'h5d: xt_byte = 8'h2b;
			8'h5e: xt_byte = 8'h63;
			8'h5f: xt_byte = 8'h76;
			8'h60: xt_byte = 8'h55;
			8'h61: xt_byte = 8'h56;
			8'h62: xt_byte = 8'h77;
			8'h63: xt_byte = 8'h78;
			8'h64: xt_byte = 8'h79;
			8'h65: xt_byte = 8'h7a;
			8'h66: xt_byte = 8'h0e; // backspace
			8'h67: xt_byte = 8'h7b;
			8'h68: xt_byte = 8'h7c;
			8'h69: xt_byte = 8'h4f;
			8'h6a: xt_byte = 8'h7d;
			8'h6b: xt_byte = 8'h4b;
			8'h6c: xt_byte = 8'h47;
			8'h6d: xt_byte = 8'h7e;
			8'h6e: xt_byte = 8'h7f;
			8'h6f: xt_byte = 8'h6f;
			8'h70: xt_byte = 8'h52; // keypad block
			8'h71: xt_byte = 8'h53;
			8'h72: xt_byte = 8'h50;
			8'h73: xt_byte = 8'h4c;
			8'h74: xt_byte = 8'h4d;
			8'h75: xt_byte = 8'h48;
			8'h76: xt_byte = 8'h01; // escape
			8'h77: xt_byte = 8'h45;
			8'h78: xt_byte = 8'h57;
			8'h79: xt_byte = 8'h4e;
			8'h7a: xt_byte = 8'h51;
			8'h7b: xt_byte = 8'h4a;
			8'h7c: xt_byte = 8'h37;
			8'h7d: xt_byte = 8'h49;
			8'h7e: xt_byte = 8'h46;
			8'h7f: xt_byte = 8'h54;
			8'h83: xt_byte = 8'h41; // F7 sits outside the main block
			8'h84: xt_byte = 8'h54;
			default: xt_byte = scan_code; // upper codes pass through
		endcase
	end

	assign xt_code.raw = xt_byte;

endmodule

// File: logic/ps2_rx.sv
// ps2_rx: keyboard line synchronizer, clock falling-edge detector and frame shifter
`timescale 1ns/1ps

module ps2_rx #(
	parameter int sync_stages = 2
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               ps2_clk,
	input  logic               ps2_data,
	output ps2_pkg::ps2_code_t scan_code,
	output logic               code_valid
);
	import ps2_pkg::*;

	localparam int cnt_w = $clog2(ps2_frame_bits);

	logic [sync_stages-1:0] clk_sync;
	logic [sync_stages-1:0] data_sync;
	logic                   clk_prev; // last synchronized clock level
	logic                   clk_fall;
	logic [cnt_w-1:0]       bit_cnt; // frame position, 0 is the start bit
	logic [7:0]             shift_reg;
	logic                   data_pos;

	// both lines idle high on the bus
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync <= '1;
			data_sync <= '1;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[sync_stages-2:0], ps2_clk};
			data_sync <= {data_sync[sync_stages-2:0], ps2_data};
			clk_prev <= clk_sync[sync_stages-1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[sync_stages-1];

	assign data_pos = (bit_cnt >= cnt_w'(ps2_first_data_pos))
		&& (bit_cnt <= cnt_w'(ps2_last_data_pos));

	// frame position counter and completion strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			code_valid <= 1'b0;
		end else begin
			code_valid <= 1'b0;
			if (clk_fall) begin
				if (bit_cnt == cnt_w'(ps2_frame_bits - 1)) begin
					bit_cnt <= '0;
					code_valid <= 1'b1; // parity and stop are not checked
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// data comes LSB first, so shift in from the top
	always_ff @(posedge clk) begin
		if (clk_fall && data_pos)
			shift_reg <= {data_sync[sync_stages-1], shift_reg[7:1]};
		if (clk_fall && bit_cnt == cnt_w'(ps2_frame_bits - 1))
			scan_code <= shift_reg; // held until the next frame ends
	end

endmodule

// File: logic/xt_pkg.sv
// xt_pkg: XT port code union, host state encoding and fixed XT codes

package xt_pkg;

	// set-1 code split into release flag and key number
	typedef struct packed {
		logic       brk; // 1 on key release
		logic [6:0] key;
	} xt_fields_t;

	// port byte, read raw by the PC or as flag plus key
	typedef union packed {
		logic [7:0] raw;
		xt_fields_t f;
	} xt_code_u;

	localparam logic [7:0] xt_self_test_ok = 8'haa; // answer to a reset request
	localparam logic [7:0] xt_idle_code = 8'h00; // nothing pending

	// host side states
	typedef enum logic [2:0] {
		st_idle    = 3'd0, // waiting for a code
		st_hold    = 3'd1, // code on pa, irq1 up
		st_ack     = 3'd2, // pb7 seen, waiting for it to drop
		st_brk     = 3'd3, // got F0, waiting for the key
		st_rst_req = 3'd4, // pb6 held low
		st_rst_rel = 3'd5  // pb6 released, waiting for pb7 low
	} xt_state_e;

endpackage

// File: logic/ps2_pkg.sv
// ps2_pkg: PS/2 frame constants, set-2 scan byte type and prefix codes

package ps2_pkg;

	// falling edges of the keyboard clock per frame
	// start, eight data bits, parity, stop
	localparam int unsigned ps2_frame_bits = 11;

	// frame positions that carry data, LSB first
	localparam int unsigned ps2_first_data_pos = 1;
	localparam int unsigned ps2_last_data_pos = 8;

	// one set-2 scan byte as it comes off the wire
	typedef logic [7:0] ps2_code_t;

	// key release announcement, next byte is the released key
	localparam ps2_code_t ps2_break_prefix = 8'hf0;

endpackage
